// ==== flist.f ====
+incdir+include
rtl/switch_pkg.sv
rtl/switch_ifs.sv
rtl/ingress_decoder.sv
rtl/voq_fifo.sv
rtl/voq_fabric.sv
rtl/egress_scheduler.sv
rtl/switch_top.sv
test/switch_tb.sv

// ==== Makefile ====
# Verilator build and run for the packet switch

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= switch_tb
RTL_TOP   ?= switch_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/100ps
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/switch_tb.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

module switch_tb;
    import switch_pkg::*;

    localparam int N           = `SW_PORTS;
    localparam int W           = `SW_DATA_WIDTH;
    localparam int MAX_LEN     = `SW_MAX_PKT;
    localparam int RAND_PKTS   = 40;    // Per input in each random phase
    localparam int FULL_PKTS   = 3;     // Per input in full_flow
    localparam int TOTAL_PKTS  = N*N + 2*N*RAND_PKTS + N*FULL_PKTS;
    localparam int CYCLE_LIMIT = TOTAL_PKTS*MAX_LEN*N*4 + 1000;
    localparam int DRAIN_LIMIT = 4000;
    localparam logic [31:0] SEED = 32'hacf8_b296;

    logic               clk = 1'b0;
    logic               arst_n = 1'b0;
    logic [N-1:0]       wr_sop = '0;
    logic [N-1:0]       wr_eop = '0;
    logic [N-1:0]       wr_vld = '0;
    logic [N*W-1:0]     wr_data = '0;
    logic [N-1:0]       ready = '1;
    logic [N-1:0]       rd_sop;
    logic [N-1:0]       rd_eop;
    logic [N-1:0]       rd_vld;
    logic [N*W-1:0]     rd_data;
    logic               full;

    // Entries are {sop, eop, data}
    logic [W+1:0]   tx_q [N][$];        // Words waiting at each input
    logic [W+1:0]   exp_q [N*N][$];     // Indexed by source*N + output
    logic [N-1:0]   tx_active = '0;
    logic [N-1:0]   rx_in_pkt = '0;
    int             rx_src [N];
    logic [N-1:0]   stalled = '0;
    logic [W+1:0]   held [N];
    int             ready_mode = 0;     // 0 always ready, 1 random, 2 output 0 held
    string          test_name = "reset_idle";
    int             err_data = 0;
    int             err_proto = 0;
    int             err_lost = 0;
    int             words_sent = 0;
    int             words_recv = 0;
    int             cycles = 0;

    switch_top uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .full    (full),
        .ready   (ready)
    );

    always #2 clk = ~clk;

    task automatic queue_packet(input int s, input int d, input int len);
        pkt_word_u      w;
        logic [W-1:0]   sent;
        logic           sop;
        logic           eop;
        for (int i = 0; i < len; i++) begin
            sop = (i == 0);
            eop = (i == len - 1);
            w.raw = W'($urandom);
            if (sop) begin
                w.hdr.dest = port_t'(d);
            end
            sent = w.raw;                   // Source field left random
            if (sop) begin
                w.hdr.src = port_t'(s);
            end
            tx_q[s].push_back({sop, eop, sent});
            exp_q[s*N + d].push_back({sop, eop, w.raw});
        end
        words_sent += len;
    endtask

    task automatic check_idle();
        assert (rd_vld == '0 && full == 1'b0) else begin
            err_proto++;
            $display("ERR %s: rd_vld and full expected %b actual %b",
                     test_name, {(N+1){1'b0}}, {rd_vld, full});
        end
    endtask

    task automatic take_word(input int d, input logic [W+1:0] got);
        pkt_word_u      w;
        logic [W+1:0]   exp;
        int             idx;
        w.raw = got[W-1:0];
        words_recv++;
        if (got[W+1]) begin
            assert (!rx_in_pkt[d]) else begin
                err_proto++;
                $display("%s: output %0d opened a packet inside another", test_name, d);
            end
            rx_src[d] = int'(w.hdr.src);
        end else begin
            assert (rx_in_pkt[d]) else begin
                err_proto++;
                $display("%s: output %0d sent a word outside a packet", test_name, d);
            end
        end
        rx_in_pkt[d] = !got[W];
        idx = rx_src[d]*N + d;
        assert (exp_q[idx].size() > 0) else begin
            err_proto++;
            $display("%s: output %0d sent an unexpected word from source %0d",
                     test_name, d, rx_src[d]);
        end
        if (exp_q[idx].size() > 0) begin
            exp = exp_q[idx].pop_front();
            assert (got == exp) else begin
                err_data++;
                $display("ERR %s: output %0d source %0d expected %h actual %h",
                         test_name, d, rx_src[d], exp, got);
            end
        end
    endtask

    function automatic bit model_empty();
        for (int p = 0; p < N; p++) begin
            if (tx_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        for (int i = 0; i < N*N; i++) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while (!model_empty() && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        repeat (8) @(negedge clk);
    endtask

    // Inputs and ready driven just after the rising edge
    always @(posedge clk) begin
        #1;
        for (int p = 0; p < N; p++) begin
            logic [W+1:0] e;
            e = '0;
            if (tx_active[p] || (tx_q[p].size() > 0 && !full && ($urandom % 4) != 0)) begin
                e = tx_q[p].pop_front();
                tx_active[p] = !e[W];
                wr_vld[p] = 1'b1;
            end else begin
                wr_vld[p] = 1'b0;
            end
            wr_sop[p] = e[W+1];
            wr_eop[p] = e[W];
            wr_data[p*W +: W] = e[W-1:0];
        end
        case (ready_mode)
            0:       ready = '1;
            1:       ready = N'($urandom);
            default: ready = {{(N-1){1'b1}}, 1'b0};
        endcase
    end

    // Outputs sampled at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            for (int d = 0; d < N; d++) begin
                logic [W+1:0] got;
                got = {rd_sop[d], rd_eop[d], rd_data[d*W +: W]};
                if (stalled[d]) begin
                    assert (rd_vld[d] && got == held[d]) else begin
                        err_proto++;
                        $display("ERR %s: output %0d held word expected %h actual %h",
                                 test_name, d, held[d], got);
                    end
                end
                stalled[d] = rd_vld[d] && !ready[d];
                held[d] = got;
                if (rd_vld[d] && ready[d]) begin
                    take_word(d, got);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: data %0d, protocol %0d, lost %0d", err_data, err_proto, err_lost);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int     n;
        logic   saw_full;
        void'($urandom(SEED));
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1 check_idle();
        end
        arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end

        test_name = "single_route";
        for (int s = 0; s < N; s++) begin
            for (int d = 0; d < N; d++) begin
                queue_packet(s, d, 1 + $urandom % MAX_LEN);
                wait_drain();
            end
        end

        test_name = "random_traffic";
        for (int i = 0; i < RAND_PKTS; i++) begin
            for (int p = 0; p < N; p++) begin
                queue_packet(p, $urandom % N, 1 + $urandom % MAX_LEN);
            end
        end
        wait_drain();

        test_name = "backpressure";
        ready_mode = 1;
        for (int i = 0; i < RAND_PKTS; i++) begin
            for (int p = 0; p < N; p++) begin
                queue_packet(p, $urandom % N, 1 + $urandom % MAX_LEN);
            end
        end
        wait_drain();
        ready_mode = 0;

        test_name = "full_flow";
        ready_mode = 2;                     // Output 0 stalled
        for (int i = 0; i < FULL_PKTS; i++) begin
            for (int p = 0; p < N; p++) begin
                queue_packet(p, 0, MAX_LEN);
            end
        end
        n = 0;
        saw_full = 1'b0;
        while (!saw_full && n < 200) begin
            @(negedge clk);
            saw_full = full;
            n++;
        end
        assert (saw_full) else begin
            err_proto++;
            $display("full_flow: full never rose while output 0 was stalled");
        end
        repeat (20) @(negedge clk);
        ready_mode = 0;
        wait_drain();
        assert (full == 1'b0) else begin
            err_proto++;
            $display("ERR %s: full after drain expected 0 actual %b", test_name, full);
        end

        test_name = "drain_end";
        repeat (20) begin
            @(negedge clk);
            check_idle();
        end
        for (int i = 0; i < N*N; i++) begin
            int lost;
            lost = 0;
            for (int k = 0; k < exp_q[i].size(); k++) begin
                if (exp_q[i][k][W]) begin
                    lost++;
                end
            end
            assert (lost == 0) else begin
                err_lost += lost;
                $display("drain_end: %0d packets from source %0d to output %0d were lost",
                         lost, i / N, i % N);
            end
        end
        assert (words_recv == words_sent) else begin
            err_data++;
            $display("ERR drain_end: word count expected %0d actual %0d", words_sent, words_recv);
        end

        $display("Errors: data %0d, protocol %0d, lost %0d", err_data, err_proto, err_lost);
        if (err_data + err_proto + err_lost == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== rtl/switch_top.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

module switch_top (
    input  logic                                    clk,
    input  logic                                    arst_n,

    input  logic [`SW_PORTS-1:0]                    wr_sop,
    input  logic [`SW_PORTS-1:0]                    wr_eop,
    input  logic [`SW_PORTS-1:0]                    wr_vld,
    input  logic [`SW_PORTS*`SW_DATA_WIDTH-1:0]     wr_data,

    output logic [`SW_PORTS-1:0]                    rd_sop,
    output logic [`SW_PORTS-1:0]                    rd_eop,
    output logic [`SW_PORTS-1:0]                    rd_vld,
    output logic [`SW_PORTS*`SW_DATA_WIDTH-1:0]     rd_data,

    output logic                                    full,
    input  logic [`SW_PORTS-1:0]                    ready
);
    import switch_pkg::*;

    localparam int N = `SW_PORTS;
    localparam int W = `SW_DATA_WIDTH;

    voq_wr_if wr_bus [N] ();
    voq_rd_if rd_bus [N] ();

    voq_fabric u_fabric (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr_bus),
        .rd     (rd_bus),
        .full   (full)
    );

    for (genvar p = 0; p < N; p++) begin : g_port
        ingress_decoder u_ingress (
            .clk      (clk),
            .arst_n   (arst_n),
            .src_port (port_t'(p)),     // Stamped into each header
            .wr_sop   (wr_sop[p]),
            .wr_eop   (wr_eop[p]),
            .wr_vld   (wr_vld[p]),
            .wr_data  (wr_data[p*W +: W]),
            .wr       (wr_bus[p])
        );

        egress_scheduler u_egress (
            .clk     (clk),
            .arst_n  (arst_n),
            .rd      (rd_bus[p]),
            .ready   (ready[p]),
            .rd_sop  (rd_sop[p]),
            .rd_eop  (rd_eop[p]),
            .rd_vld  (rd_vld[p]),
            .rd_data (rd_data[p*W +: W])
        );
    end

endmodule

// ==== rtl/egress_scheduler.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

module egress_scheduler (
    input  logic                        clk,
    input  logic                        arst_n,
    voq_rd_if.egress                    rd,
    input  logic                        ready,
    output logic                        rd_sop,
    output logic                        rd_eop,
    output logic                        rd_vld,
    output logic [`SW_DATA_WIDTH-1:0]   rd_data
);
    import switch_pkg::*;

    localparam int N = `SW_PORTS;

    logic   locked_q;   // A packet is being forwarded
    port_t  grant_q;    // Current or last granted source
    logic   first_q;    // Next popped word opens a packet
    logic   found;
    port_t  pick;
    logic   take;

    // Round robin search, starting after the last grant
    always_comb begin
        port_t idx;
        found = 1'b0;
        pick  = grant_q;
        for (int k = 1; k <= N; k++) begin
            idx = port_t'(grant_q + port_t'(k));
            if (!found && rd.pkt_avail[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    assign take     = !rd_vld || ready;     // Output register free or being taken
    assign rd.sel   = grant_q;
    assign rd.rd_en = locked_q && take;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked_q <= 1'b0;
            grant_q  <= port_t'(N - 1);     // First search starts at source 0
            first_q  <= 1'b1;
            rd_vld   <= 1'b0;
            rd_sop   <= 1'b0;
            rd_eop   <= 1'b0;
        end else begin
            if (!locked_q && found) begin
                locked_q <= 1'b1;
                grant_q  <= pick;
            end else if (rd.rd_en && rd.entry.eop) begin
                locked_q <= 1'b0;           // Release only at the end of the packet
            end

            if (rd.rd_en) begin
                first_q <= rd.entry.eop;
            end

            if (take) begin
                rd_vld <= rd.rd_en;
                rd_sop <= rd.rd_en && first_q;
                rd_eop <= rd.rd_en && rd.entry.eop;
            end
        end
    end

    // Data held while ready is low
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd_data <= rd.entry.data;
        end
    end

endmodule

// ==== rtl/voq_fabric.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

module voq_fabric (
    input  logic        clk,
    input  logic        arst_n,
    voq_wr_if.fabric    wr [`SW_PORTS],
    voq_rd_if.fabric    rd [`SW_PORTS],
    output logic        full
);
    import switch_pkg::*;

    localparam int N = `SW_PORTS;

    voq_word_t          head [N][N];    // Indexed by output, then source
    logic [N-1:0]       avail [N];      // Indexed by output, bit per source
    logic [N*N-1:0]     room_all;

    // One queue for each source and destination pair
    for (genvar s = 0; s < N; s++) begin : g_src
        for (genvar d = 0; d < N; d++) begin : g_dst
            logic push;
            logic pop;

            assign push = wr[s].wr_en && (wr[s].dest == port_t'(d));
            assign pop  = rd[d].rd_en && (rd[d].sel == port_t'(s));

            voq_fifo u_voq (
                .clk       (clk),
                .arst_n    (arst_n),
                .push      (push),
                .pop       (pop),
                .din       (wr[s].entry),
                .dout      (head[d][s]),
                .pkt_avail (avail[d][s]),
                .room      (room_all[s*N+d])
            );
        end
    end

    for (genvar d = 0; d < N; d++) begin : g_out
        assign rd[d].pkt_avail = avail[d];
        assign rd[d].entry     = head[d][rd[d].sel];   // Head of the granted source
    end

    // Any single queue short of room stops new packets everywhere
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else begin
            full <= ~&room_all;
        end
    end

endmodule

// ==== rtl/voq_fifo.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

module voq_fifo (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    push,
    input  logic                    pop,
    input  switch_pkg::voq_word_t   din,
    output switch_pkg::voq_word_t   dout,
    output logic                    pkt_avail,
    output logic                    room
);
    import switch_pkg::*;

    localparam int DEPTH = `SW_VOQ_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    // A packet may start up to two words before they show in count
    localparam int ROOM_NEED = `SW_MAX_PKT + 2;

    voq_word_t      mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;      // Entries held
    logic [CW-1:0]  pkt_cnt;    // Complete packets held

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            pkt_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            count   <= count + CW'(push) - CW'(pop);
            pkt_cnt <= pkt_cnt + CW'(push && din.eop) - CW'(pop && dout.eop);
        end
    end

    assign dout      = mem[rd_ptr];     // Head shown without a read delay
    assign pkt_avail = (pkt_cnt != '0);
    assign room      = (CW'(DEPTH) - count) >= CW'(ROOM_NEED);

endmodule

// ==== rtl/ingress_decoder.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

module ingress_decoder (
    input  logic                        clk,
    input  logic                        arst_n,
    input  switch_pkg::port_t           src_port,
    input  logic                        wr_sop,
    input  logic                        wr_eop,
    input  logic                        wr_vld,
    input  logic [`SW_DATA_WIDTH-1:0]   wr_data,
    voq_wr_if.ingress                   wr
);
    import switch_pkg::*;

    pkt_word_u  in_word;
    port_t      dest_q;     // Destination of the packet in progress
    port_t      route;

    // Header word gets the source port stamped in
    always_comb begin
        in_word.raw = wr_data;
        if (wr_sop) begin
            in_word.hdr.src = src_port;
        end
    end

    assign route = wr_sop ? in_word.hdr.dest : dest_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr.wr_en <= 1'b0;
            dest_q   <= '0;
        end else begin
            wr.wr_en <= wr_vld;
            if (wr_vld && wr_sop) begin
                dest_q <= in_word.hdr.dest;     // Held until the next sop
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            wr.dest       <= route;
            wr.entry.data <= in_word.raw;
            wr.entry.eop  <= wr_eop;
        end
    end

endmodule

// ==== rtl/switch_ifs.sv ====
`timescale 1ns/100ps
`include "switch_defines.svh"

// Queue write path, one per input port
interface voq_wr_if;
    import switch_pkg::*;

    logic       wr_en;
    port_t      dest;       // Selects the queue of this input
    voq_word_t  entry;

    modport ingress (
        output wr_en,
        output dest,
        output entry
    );

    modport fabric (
        input  wr_en,
        input  dest,
        input  entry
    );
endinterface

// Queue read path, one per output port
interface voq_rd_if;
    import switch_pkg::*;

    logic                   rd_en;      // Pops the selected head
    port_t                  sel;        // Source queue
    logic [`SW_PORTS-1:0]   pkt_avail;  // Complete packet waiting, per source
    voq_word_t              entry;      // Head of the selected queue

    modport egress (
        output rd_en,
        output sel,
        input  pkt_avail,
        input  entry
    );

    modport fabric (
        input  rd_en,
        input  sel,
        output pkt_avail,
        output entry
    );
endinterface

// ==== rtl/switch_pkg.sv ====
`include "switch_defines.svh"

package switch_pkg;

    // Port number, wide enough for every port
    typedef logic [$clog2(`SW_PORTS)-1:0] port_t;

    // Header word at the start of each packet
    typedef struct packed {
        port_t                                        dest;  // Output port
        port_t                                        src;   // Stamped by ingress
        logic [`SW_DATA_WIDTH-2*$bits(port_t)-1:0]    tag;
    } pkt_hdr_t;

    // One packet word, seen as a header or as plain data
    typedef union packed {
        pkt_hdr_t                   hdr;
        logic [`SW_DATA_WIDTH-1:0]  raw;
    } pkt_word_u;

    // Queue entry
    typedef struct packed {
        logic                       eop;
        logic [`SW_DATA_WIDTH-1:0]  data;
    } voq_word_t;

endpackage

// ==== include/switch_defines.svh ====
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

`define SW_PORTS 4              // Input and output ports

`define SW_DATA_WIDTH 16        // Bits per packet word

`define SW_MAX_PKT 8            // Longest packet, header word included

`define SW_VOQ_DEPTH 16         // Entries per virtual output queue

`endif
